//--- common/dext_pkg.sv
// data external access types
package dext_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int XLEN = 32;   // data and address width, lane logic assumes 32

  typedef logic [XLEN-1:0]   xdata_t;  // one data word
  typedef logic [XLEN-1:0]   addr_t;   // byte address
  typedef logic [XLEN/8-1:0] be_t;     // byte enables, one per lane

  ////////////////////
  // encodings
  ////////////////////

  // access size
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } biu_size_t;

  // strobe state of dext_ctrl
  typedef enum logic {
    IDLE = 1'b0,  // nothing pending
    HOLD = 1'b1   // strobe held, waiting for stb_ack
  } dext_state_t;

  ////////////////////
  // memory map
  ////////////////////

  // first address outside physical memory
  localparam addr_t MEM_LIMIT = 32'h0000_4000;

endpackage

//--- common/biu_if.sv
// ctrl to bus unit link
`timescale 1ns/1ps

interface biu_if;

  // request side, driven by dext_ctrl
  logic                stb;      // access strobe
  dext_pkg::addr_t     adr;      // byte address
  dext_pkg::biu_size_t size;     // transfer size
  logic                we;       // write enable
  dext_pkg::xdata_t    d;        // lane-placed store data

  // response side, driven by biu_pipe
  logic                stb_ack;  // access accepted this cycle
  dext_pkg::xdata_t    q;        // load data, valid with ack
  logic                ack;      // one per access, in order
  logic                err;      // error instead of ack

  modport ctrl (
    output stb,
    output adr,
    output size,
    output we,
    output d,
    input  stb_ack,
    input  q,
    input  ack,
    input  err
  );

  modport pipe (
    input  stb,
    input  adr,
    input  size,
    input  we,
    input  d,
    output stb_ack,
    output q,
    output ack,
    output err
  );

endinterface

//--- src/lsu_adapter.sv
// load/store lane adapter
`timescale 1ns/1ps

module lsu_adapter #(
  parameter int DEPTH = 2                   // accesses in flight
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clr_i,        // flush pending attributes

  input  logic                mem_req_i,
  input  dext_pkg::addr_t     mem_adr_i,
  input  dext_pkg::biu_size_t mem_size_i,
  input  logic                mem_signed_i,
  input  logic                mem_we_i,
  input  dext_pkg::xdata_t    mem_d_i,

  input  logic                adr_ack_i,    // access accepted
  input  logic                rsp_ack_i,    // unflushed response
  input  logic                rsp_err_i,
  input  dext_pkg::xdata_t    rsp_q_i,

  output dext_pkg::xdata_t    lane_d_o,     // store data on its lanes
  output dext_pkg::xdata_t    mem_q_o       // aligned, extended load data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // attribute queue, one entry per accepted access
  logic [1:0]          off_q  [DEPTH];
  dext_pkg::biu_size_t size_q [DEPTH];
  logic                sgn_q  [DEPTH];
  logic                we_q   [DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q, rd_ptr_q;

  logic                push, pop;
  dext_pkg::xdata_t    shifted;

  ////////////////////
  // store lanes
  ////////////////////

  always_comb
  begin
    unique case (mem_size_i)
      dext_pkg::BYTE: lane_d_o = {4{mem_d_i[7:0]}};   // every byte lane
      dext_pkg::HALF: lane_d_o = {2{mem_d_i[15:0]}};  // both half lanes
      default:        lane_d_o = mem_d_i;
    endcase
  end

  ////////////////////
  // attribute fifo
  ////////////////////

  assign push = adr_ack_i & mem_req_i;       // cpu inputs stable until accept
  assign pop  = rsp_ack_i | rsp_err_i;

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      off_q[wr_ptr_q]  <= mem_adr_i[1:0];
      size_q[wr_ptr_q] <= mem_size_i;
      sgn_q[wr_ptr_q]  <= mem_signed_i;
      we_q[wr_ptr_q]   <= mem_we_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else if (clr_i)
    begin
      wr_ptr_q <= '0;                        // drop everything queued
      rd_ptr_q <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + PTR_W'(1);
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + PTR_W'(1);
    end
  end

  ////////////////////
  // load extract
  ////////////////////

  assign shifted = rsp_q_i >> {off_q[rd_ptr_q], 3'b000};  // selected lane to bit 0

  always_comb
  begin
    if (we_q[rd_ptr_q])
      mem_q_o = '0;                          // stores return no data
    else
      unique case (size_q[rd_ptr_q])
        dext_pkg::BYTE: mem_q_o = {{24{sgn_q[rd_ptr_q] & shifted[7]}}, shifted[7:0]};
        dext_pkg::HALF: mem_q_o = {{16{sgn_q[rd_ptr_q] & shifted[15]}}, shifted[15:0]};
        default:        mem_q_o = shifted;
      endcase
  end

endmodule

//--- dext/dext_ctrl.sv
// data external access control
`timescale 1ns/1ps

module dext_ctrl #(
  parameter int DEPTH = 2                      // accesses in flight
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clr_i,           // flush

  // cpu side
  input  logic                mem_req_i,
  input  dext_pkg::addr_t     mem_adr_i,
  input  dext_pkg::biu_size_t mem_size_i,
  input  logic                mem_we_i,
  input  dext_pkg::xdata_t    mem_d_i,         // already lane-placed
  output logic                mem_adr_ack_o,   // address phase accepted
  output logic                mem_ack_o,       // data phase done
  output logic                mem_err_o,       // data phase error
  output dext_pkg::xdata_t    mem_q_o,

  // bus unit side
  biu_if.ctrl                 bus
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  dext_pkg::dext_state_t state_q, state_d;

  // held request, payload only
  dext_pkg::addr_t       hold_adr_q;
  dext_pkg::biu_size_t   hold_size_q;
  logic                  hold_we_q;
  dext_pkg::xdata_t      hold_d_q;

  logic [CNT_W-1:0]      inflight_q;       // accepted, not yet answered
  logic [CNT_W-1:0]      discard_q;        // flushed responses still to drop
  logic                  rsp;

  assign rsp = bus.ack | bus.err;

  ////////////////////
  // strobe fsm
  ////////////////////

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      dext_pkg::IDLE:
        if (mem_req_i && !clr_i && !bus.stb_ack) state_d = dext_pkg::HOLD;
      dext_pkg::HOLD:
        if (clr_i || bus.stb_ack) state_d = dext_pkg::IDLE;
      default: state_d = dext_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni) state_q <= dext_pkg::IDLE;
    else         state_q <= state_d;
  end

  // capture on the first strobe cycle only, keeps attributes stable
  always_ff @(posedge clk_i)
  begin
    if (state_q == dext_pkg::IDLE && mem_req_i)
    begin
      hold_adr_q  <= mem_adr_i;
      hold_size_q <= mem_size_i;
      hold_we_q   <= mem_we_i;
      hold_d_q    <= mem_d_i;
    end
  end

  assign bus.stb  = (mem_req_i | (state_q == dext_pkg::HOLD)) & ~clr_i;
  assign bus.adr  = (state_q == dext_pkg::HOLD) ? hold_adr_q  : mem_adr_i;
  assign bus.size = (state_q == dext_pkg::HOLD) ? hold_size_q : mem_size_i;
  assign bus.we   = (state_q == dext_pkg::HOLD) ? hold_we_q   : mem_we_i;
  assign bus.d    = (state_q == dext_pkg::HOLD) ? hold_d_q    : mem_d_i;

  ////////////////////
  // in-flight count
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inflight_q <= '0;
    else
      unique case ({bus.stb_ack, rsp})
        2'b10:   inflight_q <= inflight_q + CNT_W'(1);
        2'b01:   inflight_q <= inflight_q - CNT_W'(1);
        default: ;                           // none, or one in and one out
      endcase
  end

  // flush: everything in flight now gets dropped when it returns
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      discard_q <= '0;
    else if (clr_i)
      discard_q <= (rsp && |inflight_q) ? inflight_q - CNT_W'(1) : inflight_q;
    else if (|discard_q && rsp)
      discard_q <= discard_q - CNT_W'(1);
  end

  ////////////////////
  // cpu responses
  ////////////////////

  assign mem_adr_ack_o = bus.stb_ack;
  assign mem_q_o       = bus.q;
  assign mem_ack_o     = bus.ack & ~clr_i & ~|discard_q;  // drop flushed
  assign mem_err_o     = bus.err & ~clr_i & ~|discard_q;

endmodule

//--- biu/biu_pipe.sv
// pipelined bus interface unit
`timescale 1ns/1ps

module biu_pipe #(
  parameter int DEPTH = 2                     // accesses in flight
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  biu_if.pipe              bus,

  // external bus
  output logic             ext_req_o,
  input  logic             ext_gnt_i,
  output dext_pkg::addr_t  ext_adr_o,
  output logic             ext_we_o,
  output dext_pkg::be_t    ext_be_o,
  output dext_pkg::xdata_t ext_wdata_o,
  input  logic             ext_rvalid_i,      // one per issue, in order
  input  dext_pkg::xdata_t ext_rdata_i,
  input  logic             ext_err_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic             lerr_q [DEPTH];           // 1: answered locally with err
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  logic             in_bound, room, empty;
  logic             push, pop, head_lerr;

  ////////////////////
  // issue
  ////////////////////

  assign in_bound = bus.adr < dext_pkg::MEM_LIMIT;
  assign room     = cnt_q < CNT_W'(DEPTH);
  assign empty    = cnt_q == '0;

  // out of bound waits for an empty queue, its error then can't meet a bus response
  assign bus.stb_ack = bus.stb & room & (in_bound ? ext_gnt_i : empty);
  assign ext_req_o   = bus.stb & room & in_bound;

  always_comb
  begin
    unique case (bus.size)
      dext_pkg::BYTE: ext_be_o = 4'b0001 << bus.adr[1:0];
      dext_pkg::HALF: ext_be_o = bus.adr[1] ? 4'b1100 : 4'b0011;
      default:        ext_be_o = 4'b1111;
    endcase
  end

  assign ext_adr_o   = bus.adr;
  assign ext_we_o    = bus.we;
  assign ext_wdata_o = bus.d;

  ////////////////////
  // response order
  ////////////////////

  assign push      = bus.stb_ack;
  assign head_lerr = ~empty & lerr_q[rd_ptr_q];
  assign pop       = head_lerr | (~empty & ext_rvalid_i);

  always_ff @(posedge clk_i)
    if (push) lerr_q[wr_ptr_q] <= ~in_bound;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + PTR_W'(1);
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + PTR_W'(1);
      unique case ({push, pop})
        2'b10:   cnt_q <= cnt_q + CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - CNT_W'(1);
        default: ;
      endcase
    end
  end

  assign bus.q   = ext_rdata_i;
  assign bus.ack = ~empty & ~head_lerr & ext_rvalid_i & ~ext_err_i;
  assign bus.err = head_lerr | (~empty & ext_rvalid_i & ext_err_i);  // local or bus

endmodule

//--- src/dext_top.sv
// data external access top
`timescale 1ns/1ps

module dext_top #(
  parameter int DEPTH = 2                     // accesses in flight
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clr_i,

  // cpu side
  input  logic                mem_req_i,
  input  dext_pkg::addr_t     mem_adr_i,
  input  dext_pkg::biu_size_t mem_size_i,
  input  logic                mem_signed_i,
  input  logic                mem_we_i,
  input  dext_pkg::xdata_t    mem_d_i,
  output logic                mem_adr_ack_o,
  output logic                mem_ack_o,
  output logic                mem_err_o,
  output dext_pkg::xdata_t    mem_q_o,

  // external bus
  output logic                ext_req_o,
  input  logic                ext_gnt_i,
  output dext_pkg::addr_t     ext_adr_o,
  output logic                ext_we_o,
  output dext_pkg::be_t       ext_be_o,
  output dext_pkg::xdata_t    ext_wdata_o,
  input  logic                ext_rvalid_i,
  input  dext_pkg::xdata_t    ext_rdata_i,
  input  logic                ext_err_i
);

  dext_pkg::xdata_t lane_d;    // store data after lane placement
  dext_pkg::xdata_t rsp_q;     // raw bus word back to the adapter

  biu_if bus_if ();

  lsu_adapter #(.DEPTH(DEPTH)) lsu_adapter_inst (
    .clk_i, .rst_ni, .clr_i,
    .mem_req_i, .mem_adr_i, .mem_size_i, .mem_signed_i, .mem_we_i, .mem_d_i,
    .adr_ack_i (mem_adr_ack_o),
    .rsp_ack_i (mem_ack_o),
    .rsp_err_i (mem_err_o),
    .rsp_q_i   (rsp_q),
    .lane_d_o  (lane_d),
    .mem_q_o
  );

  dext_ctrl #(.DEPTH(DEPTH)) dext_ctrl_inst (
    .clk_i, .rst_ni, .clr_i,
    .mem_req_i, .mem_adr_i, .mem_size_i, .mem_we_i,
    .mem_d_i   (lane_d),
    .mem_adr_ack_o, .mem_ack_o, .mem_err_o,
    .mem_q_o   (rsp_q),
    .bus       (bus_if.ctrl)
  );

  biu_pipe #(.DEPTH(DEPTH)) biu_pipe_inst (
    .clk_i, .rst_ni,
    .bus       (bus_if.pipe),
    .ext_req_o, .ext_gnt_i, .ext_adr_o, .ext_we_o, .ext_be_o, .ext_wdata_o,
    .ext_rvalid_i, .ext_rdata_i, .ext_err_i
  );

endmodule

//--- verif/dext_assert.sv
// dext_ctrl handshake checks
`timescale 1ns/1ps

module dext_assert #(
  parameter int DEPTH = 2
) (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                clr_i,
  input logic                stb_i,
  input logic                stb_ack_i,
  input dext_pkg::addr_t     adr_i,
  input dext_pkg::biu_size_t size_i,
  input logic                we_i,
  input dext_pkg::xdata_t    d_i,
  input logic                rsp_i,       // ack or err from the bus unit
  input int unsigned         inflight_i
);

  // held strobe keeps its payload until taken or flushed
  a_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stb_i && !stb_ack_i && !clr_i) |=>
      (clr_i || ($stable(adr_i) && $stable(size_i) && $stable(we_i) && $stable(d_i))))
    else $error("strobe attributes changed while held");

  a_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    inflight_i <= DEPTH)
    else $error("in-flight count above depth");

  a_no_orphan: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i |-> inflight_i != 0)  // response needs an open access
    else $error("response with nothing in flight");

endmodule

bind dext_ctrl dext_assert #(.DEPTH(DEPTH)) dext_assert_inst (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .clr_i      (clr_i),
  .stb_i      (bus.stb),
  .stb_ack_i  (bus.stb_ack),
  .adr_i      (bus.adr),
  .size_i     (bus.size),
  .we_i       (bus.we),
  .d_i        (bus.d),
  .rsp_i      (rsp),
  .inflight_i (32'(inflight_q))
);

//--- verif/dext_tb.sv
// dext table driven testbench
`timescale 1ns/1ps

module dext_tb;

  localparam int DEPTH  = 2;
  localparam int N_ROWS = 12;
  localparam int LIMIT  = 40 * (N_ROWS + DEPTH) + 10;  // cycles incl burst and reset

  typedef struct {
    logic                we;
    dext_pkg::addr_t     adr;
    dext_pkg::biu_size_t size;
    logic                sgn;
    dext_pkg::xdata_t    wd;
    dext_pkg::xdata_t    rd;    // expected load data
    logic                err;   // expected error
    logic                flush;
    logic                stall; // hold grant low first
  } row_t;

  logic clk_i = 1'b0, rst_ni, clr_i;
  logic mem_req_i, mem_signed_i, mem_we_i;
  dext_pkg::addr_t mem_adr_i;
  dext_pkg::biu_size_t mem_size_i;
  dext_pkg::xdata_t mem_d_i, mem_q_o;
  logic mem_adr_ack_o, mem_ack_o, mem_err_o;
  logic ext_req_o, ext_gnt_i, ext_we_o, ext_rvalid_i, ext_err_i;
  dext_pkg::addr_t ext_adr_o;
  dext_pkg::be_t ext_be_o;
  dext_pkg::xdata_t ext_wdata_o, ext_rdata_i;

  dext_pkg::xdata_t mem [4096];         // 16 KiB word memory
  dext_pkg::xdata_t rsp_data [$];       // memory model answers in order
  int               rsp_due [$];
  dext_pkg::xdata_t log_q [$];          // dut responses seen
  logic             log_e [$];
  row_t             tbl [N_ROWS];
  int               cyc = 0, last_due = 0, stall_cnt = 0, seed = 90765;
  int               errors = 0, passed = 0, failed = 0;
  logic             req_seen;

  dext_top #(.DEPTH(DEPTH)) dext_top_inst (.*);

  always #50 clk_i = ~clk_i;

  function automatic dext_pkg::xdata_t fill_word(int idx);
    return (idx * 32'h9E37_79B1) ^ 32'hC0DE_0000;   // unique per word
  endfunction

  ////////////////////
  // memory model
  ////////////////////

  always @(posedge clk_i)
  begin
    int due;
    int idx;
    ext_gnt_i    <= (stall_cnt == 0) && (($random(seed) & 3) != 0);
    if (stall_cnt > 0) stall_cnt = stall_cnt - 1;
    if (ext_req_o) req_seen = 1'b1;
    if (ext_req_o && ext_gnt_i)
    begin
      idx = ext_adr_o[13:2];
      if (ext_we_o)
        for (int b = 0; b < 4; b++)
          if (ext_be_o[b]) mem[idx][8*b +: 8] = ext_wdata_o[8*b +: 8];
      due = cyc + ($random(seed) & 3);       // 1 to 4 cycles
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      rsp_data.push_back(ext_we_o ? 32'h0 : mem[idx]);
      rsp_due.push_back(due);
    end
    ext_rvalid_i <= 1'b0;
    if (rsp_due.size() != 0 && rsp_due[0] == cyc)
    begin
      ext_rvalid_i <= 1'b1;
      ext_rdata_i  <= rsp_data.pop_front();
      void'(rsp_due.pop_front());
    end
    cyc = cyc + 1;
    if (cyc > LIMIT)
    begin
      $display("SOME TESTS FAILED");
      $display("timeout: no progress after %0d cycles", cyc);
      $finish;
    end
  end

  // outputs sampled mid cycle
  always @(negedge clk_i)
    if (mem_ack_o || mem_err_o)
    begin
      log_q.push_back(mem_q_o);
      log_e.push_back(mem_err_o);
    end

  ////////////////////
  // tasks
  ////////////////////

  task automatic check_data(string name, dext_pkg::xdata_t got, dext_pkg::xdata_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERROR t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_err(string name, logic got, logic exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERROR t=%0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic issue(row_t r);
    @(posedge clk_i);
    mem_req_i    <= 1'b1;
    mem_we_i     <= r.we;
    mem_adr_i    <= r.adr;
    mem_size_i   <= r.size;
    mem_signed_i <= r.sgn;
    mem_d_i      <= r.wd;
    do @(negedge clk_i); while (!mem_adr_ack_o);   // accepted
  endtask

  task automatic count_rsp(int exp);
    repeat (2) @(negedge clk_i);
    if (log_q.size() != exp)
    begin
      errors++;
      $display("got %0d responses where %0d were expected", log_q.size(), exp);
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial
  begin
    int err0;
    row_t b;
    dext_pkg::xdata_t fw;
    for (int i = 0; i < 4096; i++) mem[i] = fill_word(i);
    //          we    adr       size            sgn   wdata         rdata         err   flush stall
    tbl[0]  = '{1'b1, 32'h0100, dext_pkg::WORD, 1'b0, 32'h876543A1, 32'h0,        1'b0, 1'b0, 1'b0};
    tbl[1]  = '{1'b0, 32'h0100, dext_pkg::WORD, 1'b0, 32'h0,        32'h876543A1, 1'b0, 1'b0, 1'b0};
    tbl[2]  = '{1'b0, 32'h0100, dext_pkg::BYTE, 1'b1, 32'h0,        32'hFFFFFFA1, 1'b0, 1'b0, 1'b0};
    tbl[3]  = '{1'b0, 32'h0101, dext_pkg::BYTE, 1'b0, 32'h0,        32'h00000043, 1'b0, 1'b0, 1'b0};
    tbl[4]  = '{1'b0, 32'h0102, dext_pkg::HALF, 1'b1, 32'h0,        32'hFFFF8765, 1'b0, 1'b0, 1'b0};
    tbl[5]  = '{1'b0, 32'h0102, dext_pkg::HALF, 1'b0, 32'h0,        32'h00008765, 1'b0, 1'b0, 1'b0};
    tbl[6]  = '{1'b1, 32'h0101, dext_pkg::BYTE, 1'b0, 32'hFFFFFF5A, 32'h0,        1'b0, 1'b0, 1'b0};
    tbl[7]  = '{1'b1, 32'h0102, dext_pkg::HALF, 1'b0, 32'hFFFF1234, 32'h0,        1'b0, 1'b0, 1'b0};
    tbl[8]  = '{1'b0, 32'h0100, dext_pkg::WORD, 1'b0, 32'h0,        32'h12345AA1, 1'b0, 1'b0, 1'b1};
    tbl[9]  = '{1'b0, 32'h4000, dext_pkg::WORD, 1'b0, 32'h0,        32'h0,        1'b1, 1'b0, 1'b0};
    tbl[10] = '{1'b0, 32'h0100, dext_pkg::WORD, 1'b0, 32'h0,        32'h0,        1'b0, 1'b1, 1'b0};
    tbl[11] = '{1'b0, 32'h0103, dext_pkg::BYTE, 1'b1, 32'h0,        32'h00000012, 1'b0, 1'b0, 1'b0};
    rst_ni = 1'b0;
    clr_i = 1'b0;
    mem_req_i = 1'b0;
    mem_we_i = 1'b0;
    mem_adr_i = '0;
    mem_size_i = dext_pkg::WORD;
    mem_signed_i = 1'b0;
    mem_d_i = '0;
    ext_gnt_i = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i = '0;
    ext_err_i = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < N_ROWS; i++)
    begin
      err0 = errors;
      log_q.delete();
      log_e.delete();
      req_seen = 1'b0;
      if (tbl[i].stall) stall_cnt = 8;
      issue(tbl[i]);
      @(posedge clk_i);
      mem_req_i <= 1'b0;
      if (tbl[i].flush)
      begin
        clr_i <= 1'b1;
        @(posedge clk_i);
        clr_i <= 1'b0;
        do @(negedge clk_i); while (rsp_due.size() != 0);  // let memory drain
        count_rsp(0);                                       // flushed load stays silent
      end
      else
      begin
        while (log_q.size() == 0) @(negedge clk_i);
        check_err("mem_err_o", log_e[0], tbl[i].err);
        if (!tbl[i].we && !tbl[i].err) check_data("mem_q_o", log_q[0], tbl[i].rd);
        if (tbl[i].err) check_err("ext_req_o", req_seen, 1'b0);
        count_rsp(1);
      end
      if (errors == err0) passed++;
      else failed++;
      $display("row %0d: %s", i, (errors == err0) ? "ok" : "bad");
    end

    // back to back loads with DEPTH outstanding
    err0 = errors;
    log_q.delete();
    log_e.delete();
    b = '{1'b0, 32'h0100, dext_pkg::WORD, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0};
    issue(b);
    b.adr = 32'h0105;
    b.size = dext_pkg::BYTE;
    issue(b);
    @(posedge clk_i);
    mem_req_i <= 1'b0;
    while (log_q.size() < DEPTH) @(negedge clk_i);
    fw = fill_word(32'h41);                           // untouched word behind 0x104
    check_err("mem_err_o", log_e[0], 1'b0);
    check_err("mem_err_o", log_e[1], 1'b0);
    check_data("mem_q_o", log_q[0], 32'h12345AA1);
    check_data("mem_q_o", log_q[1], {24'h0, fw[15:8]});
    count_rsp(DEPTH);
    if (errors == err0) passed++;
    else failed++;
    $display("burst: %s", (errors == err0) ? "ok" : "bad");

    $display("passed %0d failed %0d errors %0d", passed, failed, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- dext.f
common/dext_pkg.sv
common/biu_if.sv
src/lsu_adapter.sv
dext/dext_ctrl.sv
biu/biu_pipe.sv
src/dext_top.sv
verif/dext_assert.sv
verif/dext_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module dext_tb -f dext.f -o Vdext_tb

run: compile
	./obj_dir/Vdext_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
